//--- verilog.f
+incdir+hdl
+incdir+tests
hdl/garage_pkg.sv
hdl/order_queue.sv
hdl/slot_finder.sv
hdl/spot_table.sv
hdl/fee_meter.sv
hdl/lift_controller.sv
hdl/parking_garage.sv
tests/garage_tb.sv

//--- tests/garage_tasks.svh
`ifndef GARAGE_TASKS_SVH
`define GARAGE_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
        $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "wrong value on %s", name);
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond)
    else begin
        $display("%0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    end
endtask

// one cycle order strobe, called on a falling edge
task automatic send_order(input logic entry, input garage_pkg::plate_t p);
    in_mode  = entry;
    out_mode = !entry;
    plate    = p;
    @(negedge clock);
    in_mode  = 1'b0;
    out_mode = 1'b0;
    plate    = '0;
endtask

// follows one entry trip from the load of moving back to floor 0
task automatic wait_park(input garage_pkg::plate_t p);
    garage_pkg::spot_t spot;
    int                fl;
    int                c;

    spot = expected_spot(p);
    check_true(spot != '0, "no suitable free spot is left for an entry");
    fl = spot >> 1;
    c  = 0;
    while (moving == '0) @(negedge clock);
    check_value("moving", moving, p);
    check_value("current_floor", current_floor, 0);
    while (!park_done) begin
        @(negedge clock);
        c++;
        check_value("current_floor", current_floor, c);
    end
    check_value("park_done delay", c, fl);
    check_value("event_spot", event_spot, spot);
    check_value("moving", moving, 0);
    parked[spot]     = p;
    park_cycle[spot] = cycles;
    for (int i = fl - 1; i >= 0; i--) begin
        @(negedge clock);
        check_value("current_floor", current_floor, i);
    end
    check_value("full_sedan", full_sedan, floors_full(1'b0));
    check_value("full_suv", full_suv, floors_full(1'b1));
endtask

task automatic park_car(input garage_pkg::plate_t p);
    send_order(1'b1, p);
    wait_park(p);
endtask

task automatic pick_car(input garage_pkg::plate_t p);
    garage_pkg::spot_t spot;
    int                fl;
    int                c;
    logic [31:0]       exp_fee;

    spot = find_spot(p);
    check_true(spot != '0, "exit requested for a car that was never parked");
    fl = spot >> 1;
    send_order(1'b0, p);
    while (current_floor == '0) @(negedge clock);
    c = 1;
    check_value("current_floor", current_floor, 1);
    while (!pick_done) begin
        @(negedge clock);
        c++;
        check_value("current_floor", current_floor, c);
    end
    check_value("pick_done floor", c, fl);
    check_value("event_spot", event_spot, spot);
    check_value("moving", moving, p);
    exp_fee      = expected_fee(p, cycles - park_cycle[spot]);
    parked[spot] = '0;
    for (int i = fl - 1; i >= 0; i--) begin
        @(negedge clock);
        check_value("current_floor", current_floor, i);
        check_value("car_out_ready", car_out_ready, i == 0);
    end
    check_value("fee", fee, exp_fee);
    check_value("moving", moving, 0);
    @(negedge clock);
    check_value("car_out_ready", car_out_ready, 0);    // single pulse
    check_value("fee", fee, 0);
endtask

task automatic check_reset_state();
    check_value("current_floor", current_floor, 0);
    check_value("moving", moving, 0);
    check_value("park_done", park_done, 0);
    check_value("pick_done", pick_done, 0);
    check_value("car_out_ready", car_out_ready, 0);
    check_value("fee", fee, 0);
    check_value("full_sedan", full_sedan, 0);
    check_value("full_suv", full_suv, 0);
endtask

task automatic park_each_class();
    car_sedan    = make_plate(1'b0, 4'h3);
    car_suv      = make_plate(1'b1, 4'h5);
    car_disabled = make_plate(1'b1, `CLASS_DISABLED);
    park_car(car_sedan);
    park_car(car_suv);
    park_car(car_disabled);
endtask

// three orders on back to back cycles, served in arrival order
task automatic park_queued();
    garage_pkg::plate_t suv_b;
    garage_pkg::plate_t suv_c;

    car_hybrid = make_plate(1'b0, `CLASS_HYBRID);
    suv_b      = make_plate(1'b1, 4'h2);
    suv_c      = make_plate(1'b1, `CLASS_HYBRID);
    send_order(1'b1, car_hybrid);
    send_order(1'b1, suv_b);
    send_order(1'b1, suv_c);
    wait_park(car_hybrid);
    wait_park(suv_b);
    wait_park(suv_c);
endtask

// floor 1 picks hand over the fee in the arrival cycle
task automatic exit_each_class();
    pick_car(car_disabled);
    pick_car(car_suv);
    pick_car(car_hybrid);
    pick_car(car_sedan);
endtask

task automatic fill_sedan_floors();
    garage_pkg::plate_t p;

    while (!floors_full(1'b0)) begin
        check_value("full_sedan", full_sedan, 0);
        if (parked[4] == '0) begin
            p = make_plate(1'b0, `CLASS_DISABLED);     // floor 2 left is reserved
        end else begin
            p = make_plate(1'b0, 4'h4);
        end
        park_car(p);
    end
    check_value("full_sedan", full_sedan, 1);
    p = make_plate(1'b0, 4'h6);
    park_car(p);
    check_value("overflow spot on odd floor", event_spot[1], 1);
endtask

task automatic exit_unknown_plate();
    garage_pkg::plate_t p;

    p = make_plate(1'b1, 4'h7);
    send_order(1'b0, p);
    repeat (8) begin
        @(negedge clock);
        check_value("current_floor", current_floor, 0);
        check_value("moving", moving, 0);
        check_value("park_done", park_done, 0);
        check_value("pick_done", pick_done, 0);
        check_value("car_out_ready", car_out_ready, 0);
    end
endtask

`endif

//--- tests/garage_tb.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module garage_tb;

    // roughly 20 lift trips of at most 20 cycles each, with a wide margin
    localparam int CYCLE_LIMIT = 3000;

    logic               clock;
    logic               reset;
    garage_pkg::plate_t plate;
    logic               in_mode;
    logic               out_mode;
    garage_pkg::floor_t current_floor;
    garage_pkg::plate_t moving;
    logic               park_done;
    logic               pick_done;
    garage_pkg::spot_t  event_spot;
    logic               car_out_ready;
    garage_pkg::fee_t   fee;
    logic               full_sedan;
    logic               full_suv;

    int unsigned        cycles = 0;
    logic [31:0]        lcg_state = 32'd21;
    garage_pkg::plate_t issued [$];          // every plate handed out so far
    garage_pkg::plate_t parked [16];         // expected occupant by spot index, 0 and 1 unused
    int unsigned        park_cycle [16];
    garage_pkg::plate_t car_sedan;
    garage_pkg::plate_t car_suv;
    garage_pkg::plate_t car_disabled;
    garage_pkg::plate_t car_hybrid;

    parking_garage dut (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the lift did not finish the tests within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic garage_pkg::plate_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];                 // upper bits are the less regular ones
    endfunction

    // random plate with the class nibble and the SUV bit forced, never reused
    function automatic garage_pkg::plate_t make_plate(input logic suv, input logic [3:0] car_class);
        garage_pkg::plate_t p;
        logic               fresh;

        fresh = 1'b0;
        while (!fresh) begin
            p = lcg_next();
            p[`PLATE_BITS-1 -: 4] = car_class;
            p[0] = suv;
            fresh = 1'b1;
            foreach (issued[i]) begin
                if (issued[i] == p) fresh = 1'b0;
            end
        end
        issued.push_back(p);
        return p;
    endfunction

    function automatic garage_pkg::spot_t find_spot(input garage_pkg::plate_t p);
        for (int s = 2; s < 16; s++) begin
            if (parked[s] == p) return garage_pkg::spot_t'(s);
        end
        return '0;
    endfunction

    // spot index bit 1 is the low floor bit, so it tells odd from even floors
    function automatic logic floors_full(input logic odd_floors);
        for (int s = 2; s < 16; s++) begin
            if ((s[1] == odd_floors) && (parked[s] == '0)) return 1'b0;
        end
        return 1'b1;
    endfunction

    // allocation rules: sedans on even floors, SUVs on odd ones,
    // left spots of floors 1 and 2 kept for disabled plates
    function automatic garage_pkg::spot_t expected_spot(input garage_pkg::plate_t p);
        int   s;
        logic ok;

        for (int fl = 1; fl <= `GARAGE_FLOORS; fl++) begin
            for (int side = 0; side < 2; side++) begin
                s  = fl * 2 + side;
                ok = (parked[s] == '0);
                if (fl % 2 == 0) begin
                    ok = ok && !p[0];
                end else begin
                    ok = ok && (p[0] || floors_full(1'b0));   // sedan overflow
                end
                if (side == 0 && fl <= 2) ok = ok && (p[`PLATE_BITS-1 -: 4] == `CLASS_DISABLED);
                if (ok) return garage_pkg::spot_t'(s);
            end
        end
        return '0;
    endfunction

    function automatic logic [31:0] expected_fee(input garage_pkg::plate_t p, input int unsigned n);
        int unsigned raw;

        if (p[`PLATE_BITS-1 -: 4] == `CLASS_DISABLED) return 0;
        raw = (p[`PLATE_BITS-1 -: 4] == `CLASS_HYBRID) ? n : 2 * n;
        return (raw > 255) ? 255 : raw;
    endfunction

    `include "garage_tasks.svh"

    initial begin
        reset    = 1'b1;
        plate    = '0;
        in_mode  = 1'b0;
        out_mode = 1'b0;
        for (int s = 0; s < 16; s++) begin
            parked[s]     = '0;
            park_cycle[s] = 0;
        end
        repeat (3) @(negedge clock);
        reset = 1'b0;

        check_reset_state();
        park_each_class();
        park_queued();
        exit_each_class();
        fill_sedan_floors();
        exit_unknown_plate();

        $display("TEST OK");
        $finish;
    end

endmodule

//--- hdl/parking_garage.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module parking_garage (
    input  logic               clock,
    input  logic               reset,
    input  garage_pkg::plate_t plate,
    input  logic               in_mode,
    input  logic               out_mode,
    output garage_pkg::floor_t current_floor,
    output garage_pkg::plate_t moving,
    output logic               park_done,
    output logic               pick_done,
    output garage_pkg::spot_t  event_spot,
    output logic               car_out_ready,
    output garage_pkg::fee_t   fee,
    output logic               full_sedan,
    output logic               full_suv
);

    logic               order_valid;
    garage_pkg::order_t order_kind;
    garage_pkg::plate_t order_plate;
    logic               lift_idle;
    garage_pkg::spot_t  target_spot;
    logic               target_found;
    garage_pkg::plate_t event_plate;
    garage_pkg::plate_t spot_plates [`GARAGE_SPOTS];
    garage_pkg::fee_t   spot_fees [`GARAGE_SPOTS];

    order_queue u_queue (
        .clock       (clock),
        .reset       (reset),
        .in_mode     (in_mode),
        .out_mode    (out_mode),
        .plate       (plate),
        .lift_idle   (lift_idle),
        .order_valid (order_valid),
        .order_kind  (order_kind),
        .order_plate (order_plate)
    );

    slot_finder u_finder (
        .spot_plates  (spot_plates),
        .full_sedan   (full_sedan),
        .order_kind   (order_kind),
        .order_plate  (order_plate),
        .target_spot  (target_spot),
        .target_found (target_found)
    );

    spot_table u_table (
        .clock       (clock),
        .reset       (reset),
        .park_done   (park_done),
        .pick_done   (pick_done),
        .event_spot  (event_spot),
        .event_plate (event_plate),
        .spot_plates (spot_plates),
        .full_sedan  (full_sedan),
        .full_suv    (full_suv)
    );

    // one meter per spot, in table order
    for (genvar k = 0; k < `GARAGE_SPOTS; k++) begin : g_meter
        fee_meter u_meter (
            .clock      (clock),
            .reset      (reset),
            .spot_plate (spot_plates[k]),
            .fee        (spot_fees[k])
        );
    end

    lift_controller u_lift (
        .clock         (clock),
        .reset         (reset),
        .order_valid   (order_valid),
        .order_kind    (order_kind),
        .order_plate   (order_plate),
        .target_spot   (target_spot),
        .target_found  (target_found),
        .spot_fees     (spot_fees),
        .lift_idle     (lift_idle),
        .current_floor (current_floor),
        .moving        (moving),
        .park_done     (park_done),
        .pick_done     (pick_done),
        .event_spot    (event_spot),
        .event_plate   (event_plate),
        .car_out_ready (car_out_ready),
        .fee           (fee)
    );

endmodule

//--- hdl/lift_controller.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module lift_controller (
    input  logic               clock,
    input  logic               reset,
    input  logic               order_valid,
    input  garage_pkg::order_t order_kind,
    input  garage_pkg::plate_t order_plate,
    input  garage_pkg::spot_t  target_spot,
    input  logic               target_found,
    input  garage_pkg::fee_t   spot_fees [`GARAGE_SPOTS],
    output logic               lift_idle,
    output garage_pkg::floor_t current_floor,
    output garage_pkg::plate_t moving,
    output logic               park_done,
    output logic               pick_done,
    output garage_pkg::spot_t  event_spot,
    output garage_pkg::plate_t event_plate,
    output logic               car_out_ready,
    output garage_pkg::fee_t   fee
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_UP_PARK,
        S_UP_PICK,
        S_DOWN
    } state_t;

    state_t             state;
    garage_pkg::spot_t  goal_spot;
    garage_pkg::plate_t goal_plate;
    garage_pkg::fee_t   pick_fee;
    garage_pkg::fee_t   fee_hold;
    logic               carrying_out;     // descending with a car for the exit
    logic               accept;
    logic               at_goal;

    assign lift_idle   = (state == S_IDLE) && (current_floor == '0) && (moving == '0);
    assign accept      = lift_idle && order_valid && target_found;
    assign at_goal     = ((current_floor + 1'b1) == goal_spot[3:1]);
    assign event_spot  = goal_spot;
    assign event_plate = goal_plate;

    // meter of the spot being emptied
    always_comb begin
        pick_fee = '0;
        for (int k = 0; k < `GARAGE_SPOTS; k++) begin
            if (goal_spot == garage_pkg::spot_of(k)) pick_fee = spot_fees[k];
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            goal_spot  <= target_spot;
            goal_plate <= order_plate;
        end
        if (pick_done) fee_hold <= pick_fee;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= S_IDLE;
            current_floor <= '0;
            moving        <= '0;
            park_done     <= 1'b0;
            pick_done     <= 1'b0;
            car_out_ready <= 1'b0;
            fee           <= '0;
            carrying_out  <= 1'b0;
        end else begin
            park_done     <= 1'b0;
            pick_done     <= 1'b0;
            car_out_ready <= 1'b0;
            fee           <= '0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        if (order_kind == garage_pkg::ORDER_ENTRY) begin
                            moving <= order_plate;    // car boards at the entrance
                            state  <= S_UP_PARK;
                        end else begin
                            state  <= S_UP_PICK;
                        end
                    end
                end
                S_UP_PARK: begin
                    current_floor <= current_floor + 1'b1;
                    if (at_goal) begin
                        park_done <= 1'b1;
                        moving    <= '0;
                        state     <= S_DOWN;
                    end
                end
                S_UP_PICK: begin
                    current_floor <= current_floor + 1'b1;
                    if (at_goal) begin
                        pick_done    <= 1'b1;
                        moving       <= goal_plate;
                        carrying_out <= 1'b1;
                        state        <= S_DOWN;
                    end
                end
                S_DOWN: begin
                    current_floor <= current_floor - 1'b1;
                    if (current_floor == garage_pkg::floor_t'(1)) begin
                        state         <= S_IDLE;
                        moving        <= '0;
                        car_out_ready <= carrying_out;
                        carrying_out  <= 1'b0;
                        // from floor 1 the pick and the arrival are back to back
                        if (carrying_out) fee <= pick_done ? pick_fee : fee_hold;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/fee_meter.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module fee_meter (
    input  logic               clock,
    input  logic               reset,
    input  garage_pkg::plate_t spot_plate,
    output garage_pkg::fee_t   fee
);

    garage_pkg::fee_t    count;           // occupied cycles already completed
    garage_pkg::fee_t    run;             // occupied cycles including this one
    logic                occupied;
    logic                was_occupied;
    logic [3:0]          car_class;
    logic [`FEE_BITS:0]  doubled;

    assign occupied  = (spot_plate != '0);
    assign car_class = spot_plate[`PLATE_BITS-1 -: 4];

    // a fresh stay starts at one, the counter saturates
    always_comb begin
        if (!was_occupied) begin
            run = garage_pkg::fee_t'(1);
        end else if (&count) begin
            run = count;
        end else begin
            run = count + 1'b1;
        end
    end

    assign doubled = {run, 1'b0};

    always_comb begin
        if (!occupied || (car_class == `CLASS_DISABLED)) begin
            fee = '0;
        end else if (car_class == `CLASS_HYBRID) begin
            fee = run;                                // one per cycle
        end else if (doubled[`FEE_BITS]) begin
            fee = '1;
        end else begin
            fee = doubled[`FEE_BITS-1:0];             // two per cycle
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count        <= '0;
            was_occupied <= 1'b0;
        end else begin
            was_occupied <= occupied;
            if (occupied) count <= run;
        end
    end

endmodule

//--- hdl/spot_table.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module spot_table (
    input  logic               clock,
    input  logic               reset,
    input  logic               park_done,
    input  logic               pick_done,
    input  garage_pkg::spot_t  event_spot,
    input  garage_pkg::plate_t event_plate,
    output garage_pkg::plate_t spot_plates [`GARAGE_SPOTS],
    output logic               full_sedan,
    output logic               full_suv
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `GARAGE_SPOTS; k++) begin
                spot_plates[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `GARAGE_SPOTS; k++) begin
                if (event_spot == garage_pkg::spot_of(k)) begin
                    if (park_done) begin
                        spot_plates[k] <= event_plate;
                    end else if (pick_done) begin
                        spot_plates[k] <= '0;        // car lifted out
                    end
                end
            end
        end
    end

    // even floors hold sedans, odd floors hold SUVs
    always_comb begin
        garage_pkg::spot_t cand;

        full_sedan = 1'b1;
        full_suv   = 1'b1;
        for (int k = 0; k < `GARAGE_SPOTS; k++) begin
            cand = garage_pkg::spot_of(k);
            if (cand[1]) begin
                full_suv = full_suv && (spot_plates[k] != '0);
            end else begin
                full_sedan = full_sedan && (spot_plates[k] != '0);
            end
        end
    end

endmodule

//--- hdl/slot_finder.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module slot_finder (
    input  garage_pkg::plate_t spot_plates [`GARAGE_SPOTS],
    input  logic               full_sedan,
    input  garage_pkg::order_t order_kind,
    input  garage_pkg::plate_t order_plate,
    output garage_pkg::spot_t  target_spot,
    output logic               target_found
);

    logic is_suv;
    logic is_disabled;

    assign is_suv      = order_plate[0];      // odd plates are SUVs
    assign is_disabled = (order_plate[`PLATE_BITS-1 -: 4] == `CLASS_DISABLED);

    // slots run from floor 1 upward, left before right, first hit wins
    always_comb begin
        garage_pkg::spot_t cand;
        logic              suit;

        target_spot  = '0;
        target_found = 1'b0;
        for (int k = 0; k < `GARAGE_SPOTS; k++) begin
            cand = garage_pkg::spot_of(k);
            if (order_kind == garage_pkg::ORDER_EXIT) begin
                suit = (order_plate != '0) && (spot_plates[k] == order_plate);
            end else begin
                suit = (spot_plates[k] == '0);
                if (cand[1]) begin
                    suit = suit && (is_suv || full_sedan);   // odd floor
                end else begin
                    suit = suit && !is_suv;                  // even floor, sedans only
                end
                // left spots on the two lowest floors are reserved
                if (!cand[0] && (cand[3:1] <= 3'd2)) begin
                    suit = suit && is_disabled;
                end
            end
            if (suit && !target_found) begin
                target_spot  = cand;
                target_found = 1'b1;
            end
        end
    end

endmodule

//--- hdl/order_queue.sv
`timescale 1ns/1ps
`include "garage_config.svh"

module order_queue (
    input  logic               clock,
    input  logic               reset,
    input  logic               in_mode,
    input  logic               out_mode,
    input  garage_pkg::plate_t plate,
    input  logic               lift_idle,
    output logic               order_valid,
    output garage_pkg::order_t order_kind,
    output garage_pkg::plate_t order_plate
);

    localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);
    localparam int CNT_BITS = $clog2(`QUEUE_DEPTH + 1);

    garage_pkg::order_t kind_mem [`QUEUE_DEPTH];
    garage_pkg::plate_t plate_mem [`QUEUE_DEPTH];

    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] ptr_step(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // hold off while the popped order is still in front of the lift
    assign pop  = lift_idle && (count != '0) && !order_valid;
    assign push = (in_mode || out_mode) && ((count != CNT_BITS'(`QUEUE_DEPTH)) || pop);

    always_ff @(posedge clock) begin
        if (push) begin
            kind_mem[tail]  <= in_mode ? garage_pkg::ORDER_ENTRY : garage_pkg::ORDER_EXIT;
            plate_mem[tail] <= plate;
        end
        if (pop) begin
            order_kind  <= kind_mem[head];
            order_plate <= plate_mem[head];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            order_valid <= 1'b0;
        end else begin
            order_valid <= pop;                    // one cycle strobe per popped order
            if (push) tail <= ptr_step(tail);
            if (pop) head <= ptr_step(head);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/garage_pkg.sv
`include "garage_config.svh"

package garage_pkg;

    // floor 0 is the entrance, parking floors follow
    localparam int FLOOR_BITS = $clog2(`GARAGE_FLOORS + 1);

    typedef logic [`PLATE_BITS-1:0] plate_t;  // zero means empty

    typedef logic [FLOOR_BITS-1:0] floor_t;

    // {floor, side}, side 0 is left and 1 is right
    typedef logic [FLOOR_BITS:0] spot_t;

    typedef logic [`FEE_BITS-1:0] fee_t;

    typedef enum logic {
        ORDER_ENTRY = 1'b0,
        ORDER_EXIT  = 1'b1
    } order_t;

    // table slot k maps to floor k/2 + 1, side k%2
    function automatic spot_t spot_of(input int k);
        return spot_t'(k + 2);
    endfunction

endpackage

//--- hdl/garage_config.svh
`ifndef GARAGE_CONFIG_SVH
`define GARAGE_CONFIG_SVH

// parking floors above the entrance level
`define GARAGE_FLOORS 7

// two spots per floor, left and right
`define GARAGE_SPOTS 14

`define PLATE_BITS 16

// orders waiting for the lift
`define QUEUE_DEPTH 7

// fee width, fees saturate at all ones
`define FEE_BITS 8

// top nibble of the plate selects the car class
`define CLASS_DISABLED 4'h9
`define CLASS_HYBRID 4'h8

`endif
